//--- verilog.f
src/sound_pkg.sv
src/pulse_averager.sv
src/sound_mixer.sv
src/sample_fifo.sv
src/delta_sigma_dac.sv
src/soundcodec_top.sv
dv/tb_soundcodec_chk.sv
dv/tb_soundcodec.sv

//--- Makefile
# Verilator build and run of the sound path testbench

TOP    ?= tb_soundcodec
LOG    ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_soundcodec.sv
// inputs held per test, density counted over 4096 clocks after 4096 clocks of settling
// window is 512 enables, so the pwm ones come out as 8 times the top 9 sample bits
module tb_soundcodec;
    import sound_pkg::*;

    localparam int reset_cycles  = 4;
    // first 8 enables after reset
    localparam int quiet_cycles  = 64;
    localparam int settle_cycles = 4096;
    localparam int window_cycles = 4096;
    localparam int num_tests     = 8;
    localparam int timeout_cycles =
        ((num_tests * (settle_cycles + window_cycles) + reset_cycles + quiet_cycles) * 3) / 2;

    logic clk24;
    logic arst_n;
    logic [3:0] pulses;
    logic [tone_w-1:0] ay_a, ay_b, ay_c, rs_a, rs_b, rs_c, covox;
    logic [1:0] pwm;

    // running pwm totals, written only by the counter
    int total_l = 0;
    int total_r = 0;
    logic [1:0] pwm_seen = 2'b00;
    logic quiet_watch;
    // compare handshake
    logic check_req;
    logic cur_is_quiet;
    string cur_name;
    int meas_l, meas_r;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycle_cnt = 0;
    logic [31:0] lcg_state;

    soundcodec_top soundcodec_top_i (
        .clk24 (clk24), .arst_n (arst_n), .pulses (pulses),
        .ay_a (ay_a), .ay_b (ay_b), .ay_c (ay_c),
        .rs_a (rs_a), .rs_b (rs_b), .rs_c (rs_c),
        .covox (covox), .pwm (pwm)
    );

    always #20 clk24 = ~clk24;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------
    // reference model
    // --------------------
    // held pulses fill all four history taps with the same word
    function automatic stereo_sample_t expected_density(input logic [3:0] p,
        input logic [7:0] a_a, a_b, a_c, r_a, r_b, r_c, cov);
        int w_l, w_r, left, right;
        stereo_sample_t s;
        w_l = 16 * int'(p[2]) + 8 * int'(p[1]) + 16 * int'(p[3]);
        w_r = 16 * int'(p[0]) + 8 * int'(p[1]) + 16 * int'(p[3]);
        left  = 4 * w_l * 128 + 16 * int'(a_c) + 16 * int'(r_c);
        right = 4 * w_r * 128 + 16 * int'(a_a) + 16 * int'(r_a);
        // B and covox on both sides
        left  = left + 8 * int'(a_b) + 8 * int'(r_b) + 16 * int'(cov);
        right = right + 8 * int'(a_b) + 8 * int'(r_b) + 16 * int'(cov);
        s.chan.left  = 16'(left) ^ 16'h8000;
        s.chan.right = 16'(right) ^ 16'h8000;
        return s;
    endfunction

    task automatic check_density(input string name, input stereo_sample_t expected,
        input int ones_l, input int ones_r);
        int exp_l, exp_r;
        exp_l = 8 * int'(expected.chan.left[sample_w-1 -: ds_bits]);
        exp_r = 8 * int'(expected.chan.right[sample_w-1 -: ds_bits]);
        if (ones_l != exp_l || ones_r != exp_r)
        begin
            $display("[ERROR] %s: expected ones l=%0d r=%0d, actual l=%0d r=%0d",
                     name, exp_l, exp_r, ones_l, ones_r);
            fail_cnt++;
        end
        else
        begin
            $display("[OK] %s: sample %h, ones l=%0d r=%0d", name, expected.raw, ones_l, ones_r);
            pass_cnt++;
        end
    endtask

    task automatic check_quiet(input string name, input logic [1:0] seen);
        if (seen !== 2'b00)
        begin
            $display("[ERROR] %s: expected pwm 00, actual pwm seen %b", name, seen);
            fail_cnt++;
        end
        else
        begin
            $display("[OK] %s: pwm stayed low", name);
            pass_cnt++;
        end
    endtask

    // --------------------
    // counting and compare
    // --------------------
    // negedge, pwm is stable between rising edges
    always @(negedge clk24)
    begin
        total_l = total_l + int'(pwm[0]);
        total_r = total_r + int'(pwm[1]);
        if (quiet_watch)
            pwm_seen = pwm_seen | pwm;
    end

    always
    begin
        wait (check_req);
        if (cur_is_quiet)
            check_quiet(cur_name, pwm_seen);
        else
            check_density(cur_name,
                expected_density(pulses, ay_a, ay_b, ay_c, rs_a, rs_b, rs_c, covox),
                meas_l, meas_r);
        check_req = 1'b0;
    end

    task automatic request_check(input string name, input logic quiet);
        cur_name = name;
        cur_is_quiet = quiet;
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic apply_inputs(input logic [3:0] p,
        input logic [7:0] a_a, a_b, a_c, r_a, r_b, r_c, cov);
        @(posedge clk24);
        pulses <= p;
        ay_a <= a_a;
        ay_b <= a_b;
        ay_c <= a_c;
        rs_a <= r_a;
        rs_b <= r_b;
        rs_c <= r_c;
        covox <= cov;
    endtask

    task automatic run_window(input string name);
        int start_l, start_r;
        repeat (settle_cycles) @(posedge clk24);
        start_l = total_l;
        start_r = total_r;
        repeat (window_cycles) @(posedge clk24);
        meas_l = total_l - start_l;
        meas_r = total_r - start_r;
        request_check(name, 1'b0);
    endtask

    initial
    begin : sequencer
        logic [31:0] r0;
        logic [31:0] r1;
        int chk_fails;
        clk24 = 1'b0;
        arst_n = 1'b0;
        pulses = '0;
        ay_a = '0;
        ay_b = '0;
        ay_c = '0;
        rs_a = '0;
        rs_b = '0;
        rs_c = '0;
        covox = '0;
        check_req = 1'b0;
        quiet_watch = 1'b1;
        lcg_state = 32'h3ca3;
        repeat (reset_cycles) @(posedge clk24);
        arst_n <= 1'b1;
        // nothing popped yet, accumulators add zero
        repeat (quiet_cycles) @(posedge clk24);
        quiet_watch = 1'b0;
        request_check("reset_quiet", 1'b1);

        apply_inputs(4'b0000, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        run_window("silence");
        // timer ch0 right only, ch2 left only, beeper both
        apply_inputs(4'b0001, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        run_window("pulse_ch0");
        apply_inputs(4'b0100, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        run_window("pulse_ch2");
        apply_inputs(4'b1000, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        run_window("pulse_beeper");
        apply_inputs(4'b0000, 8'h10, 8'h20, 8'h30, 8'h05, 8'h0a, 8'h40, 8'h55);
        run_window("tones_covox");

        for (int i = 0; i < 3; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            r0 = lcg_state;
            lcg_state = lcg_next(lcg_state);
            r1 = lcg_state;
            apply_inputs(r0[31:28], r0[23:16], r0[15:8], r0[7:0],
                         r1[31:24], r1[23:16], r1[15:8], r1[7:0]);
            run_window($sformatf("random_%0d", i));
        end

        chk_fails = soundcodec_top_i.sample_fifo_i.tb_soundcodec_chk_i.fail_cnt;
        if (chk_fails != 0)
            $display("FIFO checker saw %0d assertion failures on the bus or pop side", chk_fails);
        $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, chk_fails);
        if (fail_cnt == 0 && chk_fails == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // watchdog
    initial
    begin
        while (cycle_cnt < timeout_cycles)
        begin
            @(posedge clk24);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d clocks", timeout_cycles);
        $display("test failed");
        $finish;
    end

endmodule

//--- dv/tb_soundcodec_chk.sv
// bound into sample_fifo, watches its Wishbone slave port and pop side
// fail_cnt is read by the testbench at the end of the run
module tb_soundcodec_chk (
    input logic                          clk24,
    input logic                          arst_n,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic [sound_pkg::fifo_addr_w:0] count,
    input logic                          rd_pop,
    input logic                          rd_valid
);
    import sound_pkg::*;

    // failures so far
    int fail_cnt = 0;
    logic full;

    assign full = (count == (fifo_addr_w + 1)'(fifo_depth));

    // --------------------
    // wishbone side
    // --------------------
    // ack only answers a live strobe
    ack_with_stb: assert property (@(posedge clk24) disable iff (!arst_n)
        wb_ack |-> (wb_cyc && wb_stb))
    else
    begin
        $error("wb_ack high without wb_cyc and wb_stb");
        fail_cnt = fail_cnt + 1;
    end

    // full buffer means wait states
    no_ack_full: assert property (@(posedge clk24) disable iff (!arst_n)
        full |-> !wb_ack)
    else
    begin
        $error("wb_ack high while the FIFO is full");
        fail_cnt = fail_cnt + 1;
    end

    // --------------------
    // occupancy and pop
    // --------------------
    count_bound: assert property (@(posedge clk24) disable iff (!arst_n)
        count <= (fifo_addr_w + 1)'(fifo_depth))
    else
    begin
        $error("FIFO count above depth: %0d", count);
        fail_cnt = fail_cnt + 1;
    end

    pop_when_valid: assert property (@(posedge clk24) disable iff (!arst_n)
        rd_pop |-> rd_valid)
    else
    begin
        $error("rd_pop while rd_valid is low");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind sample_fifo tb_soundcodec_chk tb_soundcodec_chk_i (
    .clk24    (clk24),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .count    (count),
    .rd_pop   (rd_pop),
    .rd_valid (rd_valid)
);

//--- src/soundcodec_top.sv
// stereo sound path, 24 MHz clock, pwm needs an external RC or transistor stage
// pulses: bit 3 beeper, bits 2..0 timer channels
module soundcodec_top (
    input  logic                         clk24,
    input  logic                         arst_n,
    input  logic [3:0]                   pulses,
    input  logic [sound_pkg::tone_w-1:0] ay_a,
    input  logic [sound_pkg::tone_w-1:0] ay_b,
    input  logic [sound_pkg::tone_w-1:0] ay_c,
    input  logic [sound_pkg::tone_w-1:0] rs_a,
    input  logic [sound_pkg::tone_w-1:0] rs_b,
    input  logic [sound_pkg::tone_w-1:0] rs_c,
    input  logic [sound_pkg::tone_w-1:0] covox,
    output logic [1:0]                   pwm
);
    import sound_pkg::*;

    // averager to mixer
    logic             tick;
    logic [sum_w-1:0] sum_l;
    logic [sum_w-1:0] sum_r;
    // mixer to FIFO over wishbone
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    logic           wb_ack;
    stereo_sample_t wb_dat;
    // FIFO to DAC
    logic           rd_pop;
    logic           rd_valid;
    stereo_sample_t rd_data;

    pulse_averager pulse_averager_i (
        .clk24  (clk24),
        .arst_n (arst_n),
        .pulses (pulses),
        .tick   (tick),
        .sum_l  (sum_l),
        .sum_r  (sum_r)
    );

    sound_mixer sound_mixer_i (
        .clk24  (clk24),
        .arst_n (arst_n),
        .tick   (tick),
        .sum_l  (sum_l),
        .sum_r  (sum_r),
        .ay_a   (ay_a),
        .ay_b   (ay_b),
        .ay_c   (ay_c),
        .rs_a   (rs_a),
        .rs_b   (rs_b),
        .rs_c   (rs_c),
        .covox  (covox),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack)
    );

    sample_fifo sample_fifo_i (
        .clk24    (clk24),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_dat   (wb_dat),
        .wb_ack   (wb_ack),
        .rd_pop   (rd_pop),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    delta_sigma_dac delta_sigma_dac_i (
        .clk24    (clk24),
        .arst_n   (arst_n),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_pop   (rd_pop),
        .pwm      (pwm)
    );

endmodule

//--- src/delta_sigma_dac.sv
// first-order sigma-delta, only the top 9 bits of each sample are used
// pwm[0] is left, pwm[1] is right; an empty FIFO repeats the last sample
module delta_sigma_dac (
    input  logic                      clk24,
    input  logic                      arst_n,
    input  logic                      rd_valid,
    input  sound_pkg::stereo_sample_t rd_data,
    output logic                      rd_pop,
    output logic [1:0]                pwm
);
    import sound_pkg::*;

    // period counter, wraps half a period after the mixer tick
    logic [tick_div_w-1:0] period_cnt;
    // enable divider
    logic [ds_div_w-1:0] ds_cnt;
    logic ds_en;
    // sample being converted
    stereo_sample_t held;
    // carry in the top bit
    logic [ds_bits:0] acc_l;
    logic [ds_bits:0] acc_r;

    // --------------------
    // sample fetch
    // --------------------
    // start at 255 so the wrap lands 256 clocks after the tick
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
            period_cnt <= {1'b0, {(tick_div_w - 1){1'b1}}};
        else
            period_cnt <= period_cnt + 1'b1;
    end

    // pop request on every wrap
    assign rd_pop = (period_cnt == '1);

    // nothing to take when the FIFO is empty
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
            held <= '0;
        else if (rd_pop && rd_valid)
            held <= rd_data;
    end

    // --------------------
    // modulators
    // --------------------
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
            ds_cnt <= '0;
        else
            ds_cnt <= ds_cnt + 1'b1;
    end

    assign ds_en = (ds_cnt == '0);

    // drop the old carry, add the sample top bits
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            acc_l <= '0;
            acc_r <= '0;
        end
        else if (ds_en)
        begin
            acc_l <= {1'b0, acc_l[ds_bits-1:0]} + held.chan.left[sample_w-1 -: ds_bits];
            acc_r <= {1'b0, acc_r[ds_bits-1:0]} + held.chan.right[sample_w-1 -: ds_bits];
        end
    end

    // carry bits straight from the accumulator registers
    assign pwm = {acc_r[ds_bits], acc_l[ds_bits]};

endmodule

//--- src/sample_fifo.sv
// write side is a Wishbone classic slave, ack comes one clock after stb
// ack is withheld while full, the master waits; reads are first-word fall-through
module sample_fifo (
    input  logic                      clk24,
    input  logic                      arst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  sound_pkg::stereo_sample_t wb_dat,
    output logic                      wb_ack,
    input  logic                      rd_pop,
    output logic                      rd_valid,
    output sound_pkg::stereo_sample_t rd_data
);
    import sound_pkg::*;

    // sample storage, no reset
    stereo_sample_t mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    // occupancy, one bit wider than the pointers
    logic [fifo_addr_w:0] count;
    logic full;
    // write request on the bus
    logic wb_req;
    // transfer completes on the edge where ack is high
    logic push;
    logic pop;

    assign full     = (count == (fifo_addr_w + 1)'(fifo_depth));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign wb_req = wb_cyc && wb_stb && wb_we;
    assign push   = wb_req && wb_ack;
    assign pop    = rd_pop && rd_valid;

    // --------------------
    // wishbone slave
    // --------------------
    // single-cycle ack, not re-raised in the cycle the master drops stb
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_req && !wb_ack && !full;
    end

    always_ff @(posedge clk24)
    begin
        if (push)
            mem[wr_ptr] <= wb_dat;
    end

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // simultaneous push and pop leaves count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- src/sound_mixer.sv
// mixing wraps modulo 2**16, loud inputs together can overflow
// a tick that arrives while a write is still pending is dropped
module sound_mixer (
    input  logic                         clk24,
    input  logic                         arst_n,
    input  logic                         tick,
    input  logic [sound_pkg::sum_w-1:0]  sum_l,
    input  logic [sound_pkg::sum_w-1:0]  sum_r,
    input  logic [sound_pkg::tone_w-1:0] ay_a,
    input  logic [sound_pkg::tone_w-1:0] ay_b,
    input  logic [sound_pkg::tone_w-1:0] ay_c,
    input  logic [sound_pkg::tone_w-1:0] rs_a,
    input  logic [sound_pkg::tone_w-1:0] rs_b,
    input  logic [sound_pkg::tone_w-1:0] rs_c,
    input  logic [sound_pkg::tone_w-1:0] covox,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output sound_pkg::stereo_sample_t    wb_dat,
    input  logic                         wb_ack
);
    import sound_pkg::*;

    // tick delayed one clock, sums are fresh by then
    logic tick_d;
    // write cycle in progress
    logic busy;
    // two's complement mixes
    logic [sample_w-1:0] mix_l;
    logic [sample_w-1:0] mix_r;
    // terms shared by both sides
    logic [sample_w-1:0] mix_common;

    // --------------------
    // mix
    // --------------------
    // B channels and covox go to both sides
    assign mix_common = sample_w'({ay_b, 3'b000}) + sample_w'({rs_b, 3'b000})
                      + sample_w'({covox, 4'b0000});
    // C on the left, A on the right
    assign mix_l = sample_w'({sum_l, 7'b0000000}) + sample_w'({ay_c, 4'b0000})
                 + sample_w'({rs_c, 4'b0000}) + mix_common;
    assign mix_r = sample_w'({sum_r, 7'b0000000}) + sample_w'({ay_a, 4'b0000})
                 + sample_w'({rs_a, 4'b0000}) + mix_common;

    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
            tick_d <= 1'b0;
        else
            tick_d <= tick;
    end

    // --------------------
    // wishbone master
    // --------------------
    // idle -> busy on tick_d, busy -> idle when ack is seen
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
            busy <= 1'b0;
        else if (busy)
        begin
            if (wb_ack)
                busy <= 1'b0;
        end
        else if (tick_d)
            busy <= 1'b1;
    end

    // word only loads when idle, held stable through wait states
    always_ff @(posedge clk24)
    begin
        if (tick_d && !busy)
        begin
            // flip the sign bit, offset binary for the DAC
            wb_dat.chan.left  <= {~mix_l[sample_w-1], mix_l[sample_w-2:0]};
            wb_dat.chan.right <= {~mix_r[sample_w-1], mix_r[sample_w-2:0]};
        end
    end

    // write only master, cyc and stb always together
    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_we  = busy;

endmodule

//--- src/pulse_averager.sv
// pulse lines are sampled only on the tick, shorter pulses in between are lost
// bit 3 of pulses is the beeper, bits 2..0 are timer channels 2..0
module pulse_averager (
    input  logic                       clk24,
    input  logic                       arst_n,
    input  logic [3:0]                 pulses,
    output logic                       tick,
    output logic [sound_pkg::sum_w-1:0] sum_l,
    output logic [sound_pkg::sum_w-1:0] sum_r
);
    import sound_pkg::*;

    // free-running sample counter
    logic [tick_div_w-1:0] tick_cnt;
    // weighted pulse words for this tick
    logic [sum_w-1:0] weight_l;
    logic [sum_w-1:0] weight_r;
    // last three words, index 0 newest
    logic [sum_w-1:0] hist_l [3];
    logic [sum_w-1:0] hist_r [3];

    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    // one-cycle strobe per sample period
    assign tick = (tick_cnt == '0);

    // --------------------
    // channel weighting
    // --------------------
    // left hears ch2, right hears ch0, ch1 at half weight on both
    assign weight_l = sum_w'({pulses[2], 4'b0000}) + sum_w'({pulses[1], 3'b000})
                    + sum_w'({pulses[3], 4'b0000});
    assign weight_r = sum_w'({pulses[0], 4'b0000}) + sum_w'({pulses[1], 3'b000})
                    + sum_w'({pulses[3], 4'b0000});

    // shift in the new word and sum it with the three before it
    always_ff @(posedge clk24 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hist_l <= '{default: '0};
            hist_r <= '{default: '0};
            sum_l  <= '0;
            sum_r  <= '0;
        end
        else if (tick)
        begin
            hist_l[2] <= hist_l[1];
            hist_l[1] <= hist_l[0];
            hist_l[0] <= weight_l;
            hist_r[2] <= hist_r[1];
            hist_r[1] <= hist_r[0];
            hist_r[0] <= weight_r;
            // max 4 * 40, fits 9 bits
            sum_l <= weight_l + hist_l[0] + hist_l[1] + hist_l[2];
            sum_r <= weight_r + hist_r[0] + hist_r[1] + hist_r[2];
        end
    end

endmodule

//--- src/sound_pkg.sv
// shared widths and rates for the stereo sound path, 24 MHz clock assumed
// one sample every 512 clocks, sigma-delta enable every 8 clocks
package sound_pkg;

    // --------------------
    // sample and input widths
    // --------------------
    // one channel of a stereo sample
    localparam int sample_w = 16;
    // tone generator and covox level
    localparam int tone_w = 8;
    // moving-average sum of four weighted pulse words
    localparam int sum_w = 9;

    // --------------------
    // rates
    // --------------------
    // sample tick every 2**9 clocks
    localparam int tick_div_w = 9;
    // sigma-delta enable every 2**3 clocks
    localparam int ds_div_w = 3;
    // sample bits fed into each accumulator
    localparam int ds_bits = 9;

    // --------------------
    // sample buffer
    // --------------------
    localparam int fifo_depth = 4;
    localparam int fifo_addr_w = 2;

    // stereo word, raw on the bus, split into channels at the DAC
    typedef union packed {
        logic [2*sample_w-1:0] raw;
        struct packed {
            logic [sample_w-1:0] left;
            logic [sample_w-1:0] right;
        } chan;
    } stereo_sample_t;

endpackage
